// File: logic/conv_ctrl_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "conv_params.svh"

module conv_ctrl_regs (
    input  wire                      clk,
    input  wire                      rst_i,
    input  wire conv_pkg::mmio_req_t mmio_i,
    input  wire conv_pkg::word_t     mem_rdata_i,
    input  wire                      eng_idle_i,
    input  wire                      eng_done_i,
    output conv_pkg::mem_port_t      mem_a_o,
    output conv_pkg::conv_cfg_t      cfg_o,
    output logic                     start_o,
    output logic                     abort_o,
    output logic                     active_o,
    output conv_pkg::word_t          rdata_o
);

    logic            is_mem;
    logic            wr;
    logic [15:0]     fm_dim_q;
    logic [15:0]     wt_off_q;
    logic [15:0]     ifm_off_q;
    logic [15:0]     ofm_off_q;
    logic            active_q;
    logic            done_q;
    logic            idle_q;
    logic            sel_mem_q;
    conv_pkg::word_t status;
    conv_pkg::word_t reg_rdata_q;

    // Only the two low byte lanes are stored
    function automatic logic [15:0] merge_lo(input logic [15:0]         old,
                                             input conv_pkg::byte_en_t we,
                                             input conv_pkg::word_t    wdata);
        logic [15:0] res;
        res = old;
        if (we[0]) begin
            res[7:0] = wdata[7:0];
        end
        if (we[1]) begin
            res[15:8] = wdata[15:8];
        end
        return res;
    endfunction

    assign is_mem = mmio_i.addr < `CONV_REG_BASE;
    assign wr     = |mmio_i.we;

    // Port A is silenced for register addresses
    assign mem_a_o.we    = is_mem ? mmio_i.we : '0;
    assign mem_a_o.addr  = mmio_i.addr[`CONV_MEM_AW+1:2];
    assign mem_a_o.wdata = mmio_i.wdata;

    assign start_o  = wr && (mmio_i.addr == `CONV_START_ADDR) && eng_idle_i && !active_q;
    assign abort_o  = wr && (mmio_i.addr == `CONV_RESET_ADDR);
    assign active_o = active_q;

    assign cfg_o.fm_dim  = fm_dim_q[`CONV_DIM_W-1:0];
    assign cfg_o.ifm_off = ifm_off_q[`CONV_MEM_AW-1:0];
    assign cfg_o.wt_off  = wt_off_q[`CONV_MEM_AW-1:0];
    assign cfg_o.ofm_off = ofm_off_q[`CONV_MEM_AW-1:0];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            fm_dim_q  <= '0;
            wt_off_q  <= '0;
            ifm_off_q <= '0;
            ofm_off_q <= '0;
        end else if (wr) begin
            case (mmio_i.addr)
                `CONV_FM_DIM_ADDR:  fm_dim_q  <= merge_lo(fm_dim_q, mmio_i.we, mmio_i.wdata);
                `CONV_WT_OFF_ADDR:  wt_off_q  <= merge_lo(wt_off_q, mmio_i.we, mmio_i.wdata);
                `CONV_IFM_OFF_ADDR: ifm_off_q <= merge_lo(ifm_off_q, mmio_i.we, mmio_i.wdata);
                `CONV_OFM_OFF_ADDR: ofm_off_q <= merge_lo(ofm_off_q, mmio_i.we, mmio_i.wdata);
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            active_q <= 1'b0;
            done_q   <= 1'b0;
            idle_q   <= 1'b1;
        end else begin
            idle_q <= eng_idle_i;
            if (abort_o || eng_done_i) begin
                active_q <= 1'b0;
            end else if (start_o) begin
                active_q <= 1'b1;
            end
            // Sticky until the next accepted start
            if (start_o) begin
                done_q <= 1'b0;
            end else if (eng_done_i) begin
                done_q <= 1'b1;
            end
        end
    end

    always_comb begin
        status                  = '0;
        status[`CONV_ST_DONE]   = done_q;
        status[`CONV_ST_IDLE]   = idle_q;
        status[`CONV_ST_ACTIVE] = active_q;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            sel_mem_q   <= 1'b0;
            reg_rdata_q <= '0;
        end else begin
            sel_mem_q <= is_mem;
            case (mmio_i.addr)
                `CONV_STATUS_ADDR:  reg_rdata_q <= status;
                `CONV_FM_DIM_ADDR:  reg_rdata_q <= {16'b0, fm_dim_q};
                `CONV_WT_OFF_ADDR:  reg_rdata_q <= {16'b0, wt_off_q};
                `CONV_IFM_OFF_ADDR: reg_rdata_q <= {16'b0, ifm_off_q};
                `CONV_OFM_OFF_ADDR: reg_rdata_q <= {16'b0, ofm_off_q};
                default:            reg_rdata_q <= '0;
            endcase
        end
    end

    // Memory data is already registered inside the RAM
    assign rdata_o = sel_mem_q ? mem_rdata_i : reg_rdata_q;

endmodule

`default_nettype wire

// File: logic/conv_engine.sv
`timescale 1ns/1ns
`default_nettype none

`include "conv_params.svh"

module conv_engine (
    input  wire                      clk,
    input  wire                      rst_i,
    input  wire                      start_i,
    input  wire                      abort_i,
    input  wire conv_pkg::conv_cfg_t cfg_i,
    input  wire conv_pkg::word_t     mem_rdata_i,
    output conv_pkg::mem_port_t      mem_b_o,
    output logic                     idle_o,
    output logic                     done_o
);

    localparam int KW = $clog2(`CONV_K);
    localparam logic [KW-1:0] LAST_TAP = KW'(`CONV_K - 1);

    conv_pkg::engine_state_t  state_q;
    conv_pkg::engine_state_t  state_d;
    conv_pkg::conv_cfg_t      cfg_q;
    conv_pkg::fm_dim_t        row_q;
    conv_pkg::fm_dim_t        col_q;
    conv_pkg::fm_dim_t        out_dim;
    logic [KW-1:0]            ki_q;
    logic [KW-1:0]            kj_q;
    conv_pkg::acc_t           acc_q;
    conv_pkg::pixel_t         pix_q;
    conv_pkg::pixel_t         wt;
    logic [2*`CONV_PIX_W-1:0] product;
    conv_pkg::mem_addr_t      img_row;
    conv_pkg::mem_addr_t      img_col;
    conv_pkg::mem_addr_t      pix_addr;
    conv_pkg::mem_addr_t      wt_addr;
    conv_pkg::mem_addr_t      out_addr;
    logic                     last_tap;
    logic                     last_col;
    logic                     last_row;

    assign out_dim = cfg_q.fm_dim - conv_pkg::fm_dim_t'(`CONV_K - 1);

    assign img_row  = conv_pkg::mem_addr_t'(row_q) + conv_pkg::mem_addr_t'(ki_q);
    assign img_col  = conv_pkg::mem_addr_t'(col_q) + conv_pkg::mem_addr_t'(kj_q);
    assign pix_addr = cfg_q.ifm_off + img_row * conv_pkg::mem_addr_t'(cfg_q.fm_dim) + img_col;
    assign wt_addr  = cfg_q.wt_off
                    + conv_pkg::mem_addr_t'(ki_q) * conv_pkg::mem_addr_t'(`CONV_K)
                    + conv_pkg::mem_addr_t'(kj_q);
    assign out_addr = cfg_q.ofm_off
                    + conv_pkg::mem_addr_t'(row_q) * conv_pkg::mem_addr_t'(out_dim)
                    + conv_pkg::mem_addr_t'(col_q);

    assign last_tap = (ki_q == LAST_TAP) && (kj_q == LAST_TAP);
    assign last_col = col_q == out_dim - conv_pkg::fm_dim_t'(1);
    assign last_row = row_q == out_dim - conv_pkg::fm_dim_t'(1);

    // Weight word arrives in MAC with the pixel held from the cycle before
    assign wt      = mem_rdata_i[`CONV_PIX_W-1:0];
    assign product = {{`CONV_PIX_W{1'b0}}, pix_q} * {{`CONV_PIX_W{1'b0}}, wt};

    assign idle_o = state_q == conv_pkg::ENG_IDLE;
    assign done_o = state_q == conv_pkg::ENG_DONE;

    always_comb begin
        mem_b_o.we    = '0;
        mem_b_o.addr  = pix_addr;
        mem_b_o.wdata = acc_q;
        case (state_q)
            conv_pkg::ENG_FETCH_WT: mem_b_o.addr = wt_addr;
            conv_pkg::ENG_STORE: begin
                mem_b_o.we   = '1;
                mem_b_o.addr = out_addr;
            end
            default: ;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            conv_pkg::ENG_IDLE:      if (start_i) state_d = conv_pkg::ENG_FETCH_PIX;
            conv_pkg::ENG_FETCH_PIX: state_d = conv_pkg::ENG_FETCH_WT;
            conv_pkg::ENG_FETCH_WT:  state_d = conv_pkg::ENG_MAC;
            conv_pkg::ENG_MAC:
                state_d = last_tap ? conv_pkg::ENG_STORE : conv_pkg::ENG_FETCH_PIX;
            conv_pkg::ENG_STORE:
                state_d = (last_col && last_row) ? conv_pkg::ENG_DONE : conv_pkg::ENG_FETCH_PIX;
            default:                 state_d = conv_pkg::ENG_IDLE;
        endcase
        if (abort_i) begin
            state_d = conv_pkg::ENG_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= conv_pkg::ENG_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            conv_pkg::ENG_IDLE: begin
                cfg_q <= cfg_i;
                row_q <= '0;
                col_q <= '0;
                ki_q  <= '0;
                kj_q  <= '0;
                acc_q <= '0;
            end
            conv_pkg::ENG_FETCH_WT: pix_q <= mem_rdata_i[`CONV_PIX_W-1:0];
            conv_pkg::ENG_MAC: begin
                acc_q <= acc_q + conv_pkg::acc_t'(product);
                // Step along the kernel row and then down
                if (kj_q == LAST_TAP) begin
                    kj_q <= '0;
                    ki_q <= (ki_q == LAST_TAP) ? '0 : ki_q + 1'b1;
                end else begin
                    kj_q <= kj_q + 1'b1;
                end
            end
            conv_pkg::ENG_STORE: begin
                acc_q <= '0;
                if (last_col) begin
                    col_q <= '0;
                    row_q <= row_q + 1'b1;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// Data widths
`define CONV_WORD_W 32
`define CONV_MEM_AW 10
`define CONV_PIX_W 8
`define CONV_DIM_W 6

// Kernel side
`define CONV_K 3

// Register window, memory occupies the bytes below it
`define CONV_REG_BASE 32'h0000_1000
`define CONV_RESET_ADDR (`CONV_REG_BASE + 32'h00)
`define CONV_START_ADDR (`CONV_REG_BASE + 32'h04)
`define CONV_STATUS_ADDR (`CONV_REG_BASE + 32'h08)
`define CONV_FM_DIM_ADDR (`CONV_REG_BASE + 32'h0C)
`define CONV_WT_OFF_ADDR (`CONV_REG_BASE + 32'h10)
`define CONV_IFM_OFF_ADDR (`CONV_REG_BASE + 32'h14)
`define CONV_OFM_OFF_ADDR (`CONV_REG_BASE + 32'h18)

// Status bits
`define CONV_ST_DONE 0
`define CONV_ST_IDLE 1
`define CONV_ST_ACTIVE 2

`endif

// File: logic/conv_pkg.sv
`default_nettype none

`include "conv_params.svh"

package conv_pkg;

    typedef logic [`CONV_WORD_W-1:0] word_t;
    typedef logic [`CONV_WORD_W/8-1:0] byte_en_t;
    typedef logic [`CONV_MEM_AW-1:0] mem_addr_t;
    typedef logic [`CONV_PIX_W-1:0] pixel_t;
    typedef logic [`CONV_WORD_W-1:0] acc_t;
    typedef logic [`CONV_DIM_W-1:0] fm_dim_t;

    // One processor bus cycle, all enables low means a read
    typedef struct packed {
        byte_en_t we;
        word_t    addr;
        word_t    wdata;
    } mmio_req_t;

    // Scalars handed to the engine, offsets in words
    typedef struct packed {
        fm_dim_t   fm_dim;
        mem_addr_t ifm_off;
        mem_addr_t wt_off;
        mem_addr_t ofm_off;
    } conv_cfg_t;

    typedef struct packed {
        byte_en_t  we;
        mem_addr_t addr;
        word_t     wdata;
    } mem_port_t;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_FETCH_PIX,
        ENG_FETCH_WT,
        ENG_MAC,
        ENG_STORE,
        ENG_DONE
    } engine_state_t;

endpackage

`default_nettype wire

// File: logic/conv_scratch_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "conv_params.svh"

module conv_scratch_mem (
    input  wire                      clk,
    input  wire conv_pkg::mem_port_t port_a_i,
    input  wire conv_pkg::mem_port_t port_b_i,
    output conv_pkg::word_t          rdata_a_o,
    output conv_pkg::word_t          rdata_b_o
);

    localparam int DEPTH = 1 << `CONV_MEM_AW;
    localparam int LANES = `CONV_WORD_W / 8;

    conv_pkg::word_t mem [0:DEPTH-1];

    // Processor side, byte lanes
    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (port_a_i.we[i]) begin
                mem[port_a_i.addr][8*i +: 8] <= port_a_i.wdata[8*i +: 8];
            end
        end
        // Engine side writes whole words, placed last so it wins a collision
        if (|port_b_i.we) begin
            mem[port_b_i.addr] <= port_b_i.wdata;
        end
    end

    always_ff @(posedge clk) begin
        rdata_a_o <= mem[port_a_i.addr];
        rdata_b_o <= mem[port_b_i.addr];
    end

endmodule

`default_nettype wire

// File: logic/conv_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module conv_subsystem (
    input  wire                     clk,
    input  wire                     rst_i,
    input  wire conv_pkg::byte_en_t mmio_we_i,
    input  wire conv_pkg::word_t    mmio_addr_i,
    input  wire conv_pkg::word_t    mmio_wdata_i,
    output conv_pkg::word_t         mmio_rdata_o,
    output logic                    conv_active_o,
    output logic                    conv_done_o
);

    conv_pkg::mmio_req_t mmio_req;
    conv_pkg::mem_port_t port_a;
    conv_pkg::mem_port_t port_b;
    conv_pkg::word_t     rdata_a;
    conv_pkg::word_t     rdata_b;
    conv_pkg::conv_cfg_t cfg;
    logic                start;
    logic                abort;
    logic                eng_idle;

    assign mmio_req = '{we: mmio_we_i, addr: mmio_addr_i, wdata: mmio_wdata_i};

    conv_ctrl_regs u_conv_ctrl_regs (
        .clk         (clk),
        .rst_i       (rst_i),
        .mmio_i      (mmio_req),
        .mem_rdata_i (rdata_a),
        .eng_idle_i  (eng_idle),
        .eng_done_i  (conv_done_o),
        .mem_a_o     (port_a),
        .cfg_o       (cfg),
        .start_o     (start),
        .abort_o     (abort),
        .active_o    (conv_active_o),
        .rdata_o     (mmio_rdata_o)
    );

    conv_engine u_conv_engine (
        .clk         (clk),
        .rst_i       (rst_i),
        .start_i     (start),
        .abort_i     (abort),
        .cfg_i       (cfg),
        .mem_rdata_i (rdata_b),
        .mem_b_o     (port_b),
        .idle_o      (eng_idle),
        .done_o      (conv_done_o)
    );

    conv_scratch_mem u_conv_scratch_mem (
        .clk       (clk),
        .port_a_i  (port_a),
        .port_b_i  (port_b),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_conv_subsystem -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -qx "TEST OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: src.f
+incdir+logic
logic/conv_pkg.sv
logic/conv_ctrl_regs.sv
logic/conv_engine.sv
logic/conv_scratch_mem.sv
logic/conv_subsystem.sv
verification/tb_conv_subsystem.sv

// File: verification/tb_conv_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

`include "conv_params.svh"

module tb_conv_subsystem;

    localparam int CLK_HALF = 10;
    // Three cycles per tap plus the store
    localparam int OUT_CYCLES = 3 * `CONV_K * `CONV_K + 1;
    // Outputs of runs with dimension 6, 4, 5 and the aborted run of dimension 5
    localparam int RUN_CYCLES = (16 + 4 + 9 + 9) * OUT_CYCLES;
    localparam int SETUP_CYCLES = 2000;
    localparam conv_pkg::word_t ST_IDLE_ONLY = conv_pkg::word_t'(1) << `CONV_ST_IDLE;
    localparam conv_pkg::word_t ST_DONE_IDLE =
        ST_IDLE_ONLY | (conv_pkg::word_t'(1) << `CONV_ST_DONE);

    logic               clk;
    logic               rst_i;
    conv_pkg::byte_en_t mmio_we;
    conv_pkg::word_t    mmio_addr;
    conv_pkg::word_t    mmio_wdata;
    conv_pkg::word_t    mmio_rdata;
    logic               conv_active;
    logic               conv_done;
    logic               done_prev = 1'b0;
    logic [31:0]        lcg_state;
    int                 error_count;

    // Copy of what the memory should hold
    conv_pkg::word_t shadow [0:(1 << `CONV_MEM_AW)-1];

    conv_subsystem u_conv_subsystem (
        .clk           (clk),
        .rst_i         (rst_i),
        .mmio_we_i     (mmio_we),
        .mmio_addr_i   (mmio_addr),
        .mmio_wdata_i  (mmio_wdata),
        .mmio_rdata_o  (mmio_rdata),
        .conv_active_o (conv_active),
        .conv_done_o   (conv_done)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial begin
        #((2 * RUN_CYCLES + SETUP_CYCLES) * 2 * CLK_HALF);
        $display("Timeout: the simulation ran past its cycle budget");
        $display("TEST FAILED");
        $finish;
    end

    function automatic conv_pkg::word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic conv_pkg::word_t word_addr(input int idx);
        return conv_pkg::word_t'(idx * 4);
    endfunction

    task automatic check_value(input string name, input conv_pkg::word_t got,
                               input conv_pkg::word_t expected);
        if (got !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic bus_write(input conv_pkg::word_t addr, input conv_pkg::word_t data,
                             input conv_pkg::byte_en_t we);
        @(posedge clk);
        mmio_we    <= we;
        mmio_addr  <= addr;
        mmio_wdata <= data;
        @(posedge clk);
        mmio_we <= '0;
    endtask

    // Read data is registered and sampled mid-cycle after the capturing edge
    task automatic bus_read(input conv_pkg::word_t addr, output conv_pkg::word_t data);
        @(posedge clk);
        mmio_we   <= '0;
        mmio_addr <= addr;
        @(posedge clk);
        @(negedge clk);
        data = mmio_rdata;
    endtask

    task automatic check_read(input string name, input conv_pkg::word_t addr,
                              input conv_pkg::word_t expected);
        conv_pkg::word_t data;
        bus_read(addr, data);
        check_value(name, data, expected);
    endtask

    task automatic load_random(input int base, input int count);
        conv_pkg::word_t     w;
        conv_pkg::mem_addr_t a;
        for (int k = 0; k < count; k++) begin
            w = lcg_next();
            a = conv_pkg::mem_addr_t'(base + k);
            shadow[a] = w;
            bus_write(word_addr(base + k), w, 4'hF);
        end
    endtask

    task automatic check_region(input int base, input int count);
        conv_pkg::mem_addr_t a;
        for (int k = 0; k < count; k++) begin
            a = conv_pkg::mem_addr_t'(base + k);
            check_read($sformatf("mem[%0d]", base + k), word_addr(base + k), shadow[a]);
        end
    endtask

    // Valid convolution on the low byte of each word
    function automatic conv_pkg::word_t conv_ref(input int dim, input int ifm, input int wt,
                                                 input int row, input int col);
        conv_pkg::word_t     sum;
        conv_pkg::mem_addr_t pa;
        conv_pkg::mem_addr_t wa;
        sum = '0;
        for (int i = 0; i < `CONV_K; i++) begin
            for (int j = 0; j < `CONV_K; j++) begin
                pa = conv_pkg::mem_addr_t'(ifm + (row + i) * dim + col + j);
                wa = conv_pkg::mem_addr_t'(wt + `CONV_K * i + j);
                sum += 32'(shadow[pa][7:0]) * 32'(shadow[wa][7:0]);
            end
        end
        return sum;
    endfunction

    task automatic configure(input int dim, input int ifm, input int wt, input int ofm);
        bus_write(`CONV_FM_DIM_ADDR, 32'(dim), 4'hF);
        bus_write(`CONV_IFM_OFF_ADDR, 32'(ifm), 4'hF);
        bus_write(`CONV_WT_OFF_ADDR, 32'(wt), 4'hF);
        bus_write(`CONV_OFM_OFF_ADDR, 32'(ofm), 4'hF);
    endtask

    task automatic start_run(input logic double_start);
        bus_write(`CONV_START_ADDR, 32'd1, 4'h1);
        @(negedge clk);
        check_value("conv_active_o after start", 32'(conv_active), 32'd1);
        if (double_start) begin
            // A taken second start would move the results to this window
            bus_write(`CONV_OFM_OFF_ADDR, 32'd900, 4'hF);
            bus_write(`CONV_START_ADDR, 32'd1, 4'h1);
        end
    endtask

    task automatic wait_done(input int poll_limit);
        conv_pkg::word_t st;
        int              polls;
        st    = '0;
        polls = 0;
        while (!st[`CONV_ST_DONE] && polls < poll_limit) begin
            bus_read(`CONV_STATUS_ADDR, st);
            polls++;
            if (!st[`CONV_ST_DONE]) begin
                check_value("status.active", 32'(st[`CONV_ST_ACTIVE]), 32'd1);
            end
        end
        if (!st[`CONV_ST_DONE]) begin
            error_count++;
            $display("Engine did not report done within %0d status polls", poll_limit);
        end else begin
            check_value("status.active at done", 32'(st[`CONV_ST_ACTIVE]), 32'd0);
            check_read("status after done", `CONV_STATUS_ADDR, ST_DONE_IDLE);
        end
    endtask

    task automatic check_outputs(input int dim, input int ifm, input int wt, input int ofm);
        int                  od;
        conv_pkg::word_t     expected;
        conv_pkg::mem_addr_t a;
        od = dim - (`CONV_K - 1);
        for (int r = 0; r < od; r++) begin
            for (int c = 0; c < od; c++) begin
                expected = conv_ref(dim, ifm, wt, r, c);
                a = conv_pkg::mem_addr_t'(ofm + r * od + c);
                shadow[a] = expected;
                check_read($sformatf("out[%0d][%0d]", r, c), word_addr(ofm + r * od + c),
                           expected);
            end
        end
    endtask

    task automatic full_run(input int dim, input int ifm, input int wt, input int ofm,
                            input logic double_start);
        load_random(ifm, dim * dim);
        load_random(wt, `CONV_K * `CONV_K);
        configure(dim, ifm, wt, ofm);
        start_run(double_start);
        wait_done((dim - 2) * (dim - 2) * OUT_CYCLES);
        check_outputs(dim, ifm, wt, ofm);
        check_region(ifm, dim * dim);
        check_region(wt, `CONV_K * `CONV_K);
    endtask

    // Active must be high during the done pulse and low right after it
    always @(negedge clk) begin
        if (done_prev) begin
            check_value("conv_active_o after done", 32'(conv_active), 32'd0);
        end
        if (conv_done) begin
            check_value("conv_active_o at done", 32'(conv_active), 32'd1);
        end
        done_prev = conv_done;
    end

    initial begin
        rst_i       <= 1'b1;
        mmio_we     <= '0;
        mmio_addr   <= '0;
        mmio_wdata  <= '0;
        lcg_state   = 32'd50;
        error_count = 0;
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;

        @(negedge clk);
        check_value("conv_active_o after reset", 32'(conv_active), 32'd0);
        check_read("status after reset", `CONV_STATUS_ADDR, ST_IDLE_ONLY);
        check_read("fm_dim after reset", `CONV_FM_DIM_ADDR, 32'd0);
        check_read("wt_off after reset", `CONV_WT_OFF_ADDR, 32'd0);
        check_read("ifm_off after reset", `CONV_IFM_OFF_ADDR, 32'd0);
        check_read("ofm_off after reset", `CONV_OFM_OFF_ADDR, 32'd0);

        // Partial lane writes to a scalar whose upper half is never stored
        bus_write(`CONV_WT_OFF_ADDR, 32'hAABB_CC11, 4'b0001);
        bus_write(`CONV_WT_OFF_ADDR, 32'h1122_3344, 4'b0010);
        bus_write(`CONV_WT_OFF_ADDR, 32'h5566_7788, 4'b1000);
        check_read("wt_off lanes", `CONV_WT_OFF_ADDR, 32'h0000_3311);
        bus_write(`CONV_OFM_OFF_ADDR, 32'hFFFF_FFFF, 4'hF);
        check_read("ofm_off full", `CONV_OFM_OFF_ADDR, 32'h0000_FFFF);

        bus_write(word_addr(10), 32'h1122_3344, 4'hF);
        bus_write(word_addr(10), 32'h00AA_0000, 4'b0100);
        bus_write(word_addr(10), 32'hBB00_00CC, 4'b1001);
        check_read("mem[10] lanes", word_addr(10), 32'hBBAA_33CC);

        full_run(6, 100, 200, 300, 1'b0);
        full_run(4, 400, 450, 500, 1'b1);
        check_region(300, 16);

        // Abort part way through a run
        load_random(600, 25);
        load_random(650, `CONV_K * `CONV_K);
        configure(5, 600, 650, 700);
        start_run(1'b0);
        repeat (40) @(posedge clk);
        bus_write(`CONV_RESET_ADDR, 32'd1, 4'h1);
        @(negedge clk);
        check_value("conv_active_o after abort", 32'(conv_active), 32'd0);
        check_read("status after abort", `CONV_STATUS_ADDR, ST_IDLE_ONLY);
        full_run(5, 600, 650, 700, 1'b0);

        $display("Simulation finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
